// ==== logic/sys86_defines.svh ====
`ifndef SYS86_DEFINES_SVH
`define SYS86_DEFINES_SVH

//////////////////////////////
// Watchdog
//////////////////////////////

// Width of the vblank counter
// MSB of the counter is the main CPU reset
`define WATCHDOG_WIDTH 4

// Count at which the counter wraps back to zero
// With no kicks reset rises at count 8 and drops on the wrap
`define WATCHDOG_LAST 10

//////////////////////////////
// I/O windows, upper five address bits
//////////////////////////////

// Watchdog kick, 8000h
`define WDOG_ADDR 5'b10000

// Main CPU interrupt acknowledge, 8800h
`define INTACK_ADDR 5'b10001

// Tile layer latches, first window at D000h
`define LATCH0_BASE 5'b11010

// Tile layer latches, second window at D800h
`define LATCH1_BASE 5'b11011

`endif

// ==== logic/sys86Pkg.sv ====
`default_nettype none

package sys86Pkg;

	//////////////////////////////
	// Main CPU bus
	//////////////////////////////

	// One bus cycle as seen by the glue logic
	// Write is a single clock strobe, address held while it is high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        write;
	} cpuBusT;

	// Decoded I/O register hit by a write
	// ioNone whenever the strobe is low
	typedef enum logic [2:0] {
		ioNone,
		ioWatchdog,
		ioIntAck,
		ioLatch0,
		ioLatch1
	} ioTargetT;

	//////////////////////////////
	// Memory chip selects
	//////////////////////////////

	// All active high
	typedef struct packed {
		// 0000h - 1FFFh
		logic spriteRam;
		// 2000h - 3FFFh
		logic videoRam0;
		// 4000h - 5FFFh
		logic videoRam1;
		// 6000h - 7FFFh, banked ROM
		logic bankRom;
		// 8000h - FFFFh, reads only
		logic mainRom;
	} chipSelT;

	//////////////////////////////
	// Tile layer registers
	//////////////////////////////

	// One tile layer
	// scrollX[8] comes from bit 0 of the offset 0 byte
	// prio comes from bits 7:5 of the same byte
	typedef struct packed {
		logic [8:0] scrollX;
		logic [2:0] prio;
		logic [7:0] scrollY;
	} layerRegsT;

	// Both layers plus the shared ROM bank select
	typedef struct packed {
		layerRegsT  layerA;
		layerRegsT  layerB;
		logic [7:0] romBank;
	} tileRegsT;

endpackage

`default_nettype wire

// ==== logic/cpuPhaseGen.sv ====
`default_nettype none
`timescale 1ns/10ps

module cpuPhaseGen (
	input  logic clk6M,
	input  logic reset,
	input  logic clk0,
	output logic cpuQ
);

	// Phase counter, a 74LS161 on the board
	logic [1:0] phaseCnt;
	logic [1:0] phaseNext;

	// Counter is held clear while the reference phase is low
	always_comb begin
		if (!clk0) begin
			phaseNext = 2'd0;
		end else begin
			phaseNext = phaseCnt + 2'd1;
		end
	end

	// XOR of the two counter bits gives Q, a quarter period off the count
	// Registered from the next count so Q always matches the counter
	always_ff @(posedge clk6M) begin
		if (reset) begin
			phaseCnt <= 2'd0;
			cpuQ     <= 1'b0;
		end else begin
			phaseCnt <= phaseNext;
			cpuQ     <= phaseNext[1] ^ phaseNext[0];
		end
	end

endmodule

`default_nettype wire

// ==== logic/mainAddrDecoder.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "sys86_defines.svh"

module mainAddrDecoder (
	input  logic [15:0]        addr,
	input  logic               write,
	output sys86Pkg::chipSelT  chipSel,
	output sys86Pkg::ioTargetT ioTarget
);

	// Upper address bits used by the decode
	logic [2:0] memPage;
	logic [4:0] ioPage;

	assign memPage = addr[15:13];
	assign ioPage  = addr[15:11];

	//////////////////////////////
	// Memory chip selects
	//////////////////////////////

	// Pure combinational decode, no latency
	always_comb begin
		chipSel = '0;
		case (memPage)
			// Sprite RAM
			3'b000: begin
				chipSel.spriteRam = 1'b1;
			end
			// First video RAM
			3'b001: begin
				chipSel.videoRam0 = 1'b1;
			end
			// Second video RAM
			3'b010: begin
				chipSel.videoRam1 = 1'b1;
			end
			// Banked ROM
			3'b011: begin
				chipSel.bankRom = 1'b1;
			end
			// Upper half is program ROM on reads
			// writes up here are I/O, so the ROM stays off
			default: begin
				chipSel.mainRom = ~write;
			end
		endcase
	end

	//////////////////////////////
	// I/O write targets
	//////////////////////////////

	// Only a live strobe produces a target
	// Everything downstream trusts ioTarget alone
	always_comb begin
		ioTarget = sys86Pkg::ioNone;
		if (write) begin
			case (ioPage)
				// Watchdog kick
				`WDOG_ADDR: begin
					ioTarget = sys86Pkg::ioWatchdog;
				end
				// Vblank interrupt acknowledge
				`INTACK_ADDR: begin
					ioTarget = sys86Pkg::ioIntAck;
				end
				// Scroll, priority and bank, first window
				`LATCH0_BASE: begin
					ioTarget = sys86Pkg::ioLatch0;
				end
				// Scroll, priority and bank, second window
				`LATCH1_BASE: begin
					ioTarget = sys86Pkg::ioLatch1;
				end
				// Writes elsewhere go to RAM only
				default: begin
					ioTarget = sys86Pkg::ioNone;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/vblankWatchdog.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "sys86_defines.svh"

module vblankWatchdog #(
	parameter int width = `WATCHDOG_WIDTH
) (
	input  logic               clk6M,
	input  logic               reset,
	input  logic               vblank,
	input  sys86Pkg::ioTargetT ioTarget,
	output logic               mainReset,
	output logic               mainIrq
);

	//////////////////////////////
	// Vblank edge
	//////////////////////////////

	// Previous vblank sample
	logic vblankPrev;
	// High for the one clock where vblank has just risen
	logic vblankStart;

	assign vblankStart = vblank & ~vblankPrev;

	always_ff @(posedge clk6M) begin
		if (reset) begin
			vblankPrev <= 1'b0;
		end else begin
			vblankPrev <= vblank;
		end
	end

	//////////////////////////////
	// Watchdog
	//////////////////////////////

	// Frames since the last kick
	logic [width-1:0] wdCount;
	// Kick seen since the last vblank start
	logic             kickPending;
	// Counter goes back to zero on this vblank
	logic             countClear;

	assign countClear = kickPending | (wdCount == width'(`WATCHDOG_LAST));

	always_ff @(posedge clk6M) begin
		if (reset) begin
			wdCount     <= '0;
			kickPending <= 1'b0;
		end else begin
			// Counter only moves once per frame
			if (vblankStart) begin
				if (countClear) begin
					wdCount <= '0;
				end else begin
					wdCount <= wdCount + 1'b1;
				end
				kickPending <= 1'b0;
			end
			// A kick on the vblank clock itself counts for the next frame
			if (ioTarget == sys86Pkg::ioWatchdog) begin
				kickPending <= 1'b1;
			end
		end
	end

	// Main CPU held in reset while the MSB is set
	assign mainReset = wdCount[width-1];

	//////////////////////////////
	// Vblank interrupt
	//////////////////////////////

	// Raised every frame, dropped by the acknowledge write
	// A new frame wins over a simultaneous acknowledge
	always_ff @(posedge clk6M) begin
		if (reset) begin
			mainIrq <= 1'b0;
		end else if (vblankStart) begin
			mainIrq <= 1'b1;
		end else if (ioTarget == sys86Pkg::ioIntAck) begin
			mainIrq <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== logic/tileLatchBank.sv ====
`default_nettype none
`timescale 1ns/10ps

module tileLatchBank (
	input  logic               clk6M,
	input  logic               reset,
	input  sys86Pkg::ioTargetT ioTarget,
	input  logic [2:0]         offset,
	input  logic [7:0]         data,
	output sys86Pkg::tileRegsT tileRegs
);

	// Layout inside each 8 byte window
	//   0..2  layer A
	//   3     ROM bank select
	//   4..6  layer B
	//   7     not decoded

	// Held register state
	sys86Pkg::tileRegsT regs;
	// Either latch window strobed this clock
	logic               latchWrite;
	// Offset 3, the bank select slot
	logic               bankSel;
	// Layer byte index within a layer group
	logic [1:0]         layerByte;

	assign latchWrite = (ioTarget == sys86Pkg::ioLatch0) ||
		(ioTarget == sys86Pkg::ioLatch1);
	assign layerByte  = offset[1:0];
	assign bankSel    = (offset == 3'd3);

	//////////////////////////////
	// Layer byte merge
	//////////////////////////////

	// Returns the layer with one byte replaced
	// Byte 3 of a group leaves the layer untouched
	function automatic sys86Pkg::layerRegsT mergeLayer(
		input sys86Pkg::layerRegsT cur,
		input logic [1:0]          sel,
		input logic [7:0]          value
	);
		sys86Pkg::layerRegsT nxt;
		nxt = cur;
		case (sel)
			// Priority in the top bits, scroll X MSB in bit 0
			2'd0: begin
				nxt.prio       = value[7:5];
				nxt.scrollX[8] = value[0];
			end
			// Scroll X low byte
			2'd1: begin
				nxt.scrollX[7:0] = value;
			end
			// Scroll Y
			2'd2: begin
				nxt.scrollY = value;
			end
			default: begin
				nxt = cur;
			end
		endcase
		return nxt;
	endfunction

	//////////////////////////////
	// Latches
	//////////////////////////////

	// Both windows land on the one register set here
	// The bank select at offset 3 is shared between them
	always_ff @(posedge clk6M) begin
		if (reset) begin
			regs <= '0;
		end else if (latchWrite) begin
			if (bankSel) begin
				regs.romBank <= data;
			end else if (offset[2]) begin
				// Upper half of the window, layer B
				regs.layerB <= mergeLayer(regs.layerB, layerByte, data);
			end else begin
				// Lower half of the window, layer A
				regs.layerA <= mergeLayer(regs.layerA, layerByte, data);
			end
		end
	end

	// Registers go straight out to the tile generators
	assign tileRegs = regs;

endmodule

`default_nettype wire

// ==== logic/mainBusCtrl.sv ====
`default_nettype none
`timescale 1ns/10ps

module mainBusCtrl (
	input  logic               clk6M,
	input  logic               reset,
	input  sys86Pkg::cpuBusT   bus,
	input  logic               vblank,
	input  logic               clk0,
	output sys86Pkg::chipSelT  chipSel,
	output sys86Pkg::tileRegsT tileRegs,
	output logic               mainReset,
	output logic               mainIrq,
	output logic               cpuQ
);

	// Decoded write target, already qualified by the strobe
	sys86Pkg::ioTargetT ioTarget;

	//////////////////////////////
	// Address decode
	//////////////////////////////

	mainAddrDecoder i_mainAddrDecoder (
		.addr    (bus.addr),
		.write   (bus.write),
		.chipSel (chipSel),
		.ioTarget(ioTarget)
	);

	//////////////////////////////
	// Watchdog and vblank IRQ
	//////////////////////////////

	vblankWatchdog i_vblankWatchdog (
		.clk6M    (clk6M),
		.reset    (reset),
		.vblank   (vblank),
		.ioTarget (ioTarget),
		.mainReset(mainReset),
		.mainIrq  (mainIrq)
	);

	//////////////////////////////
	// Tile layer latches
	//////////////////////////////

	// Low three address bits pick the byte in a window
	tileLatchBank i_tileLatchBank (
		.clk6M   (clk6M),
		.reset   (reset),
		.ioTarget(ioTarget),
		.offset  (bus.addr[2:0]),
		.data    (bus.data),
		.tileRegs(tileRegs)
	);

	//////////////////////////////
	// CPU clock phase
	//////////////////////////////

	cpuPhaseGen i_cpuPhaseGen (
		.clk6M(clk6M),
		.reset(reset),
		.clk0 (clk0),
		.cpuQ (cpuQ)
	);

endmodule

`default_nettype wire

// ==== verif/tbMainBusCtrl.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "sys86_defines.svh"

module tbMainBusCtrl;

	localparam int DRIVE_DELAY = 2;
	// Vblank starts at which reset rises and falls with no kicks
	localparam int RESET_RISE_FRAME = 8;
	localparam int RESET_FALL_FRAME = 11;

	logic               clk6M;
	logic               reset;
	logic               vblank;
	logic               clk0;
	sys86Pkg::cpuBusT   bus;
	sys86Pkg::chipSelT  chipSel;
	sys86Pkg::tileRegsT tileRegs;
	logic               mainReset;
	logic               mainIrq;
	logic               cpuQ;

	// Reference model state
	logic [7:0]  shadow [0:7];
	int          modelCount;
	bit          modelPending;
	bit          modelIrq;
	logic [1:0]  modelPhase;
	logic [31:0] lfsrState;

	// Compare request and bookkeeping
	event        checkReq;
	string       testName;
	string       cmpName;
	logic [47:0] cmpExp;
	logic [47:0] cmpAct;
	int          testCount;
	int          checkCount;
	int          errorCount;
	int          testChecks;
	int          testErrors;

	mainBusCtrl i_mainBusCtrl (
		.clk6M    (clk6M),
		.reset    (reset),
		.bus      (bus),
		.vblank   (vblank),
		.clk0     (clk0),
		.chipSel  (chipSel),
		.tileRegs (tileRegs),
		.mainReset(mainReset),
		.mainIrq  (mainIrq),
		.cpuQ     (cpuQ)
	);

	initial begin
		clk6M = 1'b0;
		forever #10 clk6M = ~clk6M;
	end

	//////////////////////////////
	// Reference functions
	//////////////////////////////

	// Memory map by address range
	function automatic sys86Pkg::chipSelT refChipSel(logic [15:0] a, logic w);
		sys86Pkg::chipSelT c;
		c.spriteRam = (a < 16'h2000);
		c.videoRam0 = (a >= 16'h2000) && (a < 16'h4000);
		c.videoRam1 = (a >= 16'h4000) && (a < 16'h6000);
		c.bankRom   = (a >= 16'h6000) && (a < 16'h8000);
		// ROM answers reads only
		c.mainRom   = (a >= 16'h8000) && !w;
		return c;
	endfunction

	// Fields rebuilt from the shadow bytes, offset 7 never used
	function automatic sys86Pkg::tileRegsT refTileRegs();
		sys86Pkg::tileRegsT t;
		t.layerA.scrollX = {shadow[0][0], shadow[1]};
		t.layerA.prio    = shadow[0][7:5];
		t.layerA.scrollY = shadow[2];
		t.romBank        = shadow[3];
		t.layerB.scrollX = {shadow[4][0], shadow[5]};
		t.layerB.prio    = shadow[4][7:5];
		t.layerB.scrollY = shadow[6];
		return t;
	endfunction

	function automatic int nextWdCount(int count, bit pending);
		if (pending || count == `WATCHDOG_LAST) begin
			return 0;
		end
		return count + 1;
	endfunction

	// Reset follows the counter MSB
	function automatic logic refReset(int count);
		return (count >> (`WATCHDOG_WIDTH - 1)) & 1;
	endfunction

	// Q is high in the middle two quarters of the count
	function automatic logic refCpuQ(logic [1:0] phase);
		return (phase == 2'd1) || (phase == 2'd2);
	endfunction

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] lfsrStep(logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	function logic [31:0] takeBits(int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsrState = lfsrStep(lfsrState);
			r = {r[30:0], lfsrState[0]};
		end
		return r;
	endfunction

	//////////////////////////////
	// Compare process
	//////////////////////////////

	always @(checkReq) begin
		checkCount++;
		testChecks++;
		assert (cmpAct === cmpExp) else begin
			$display("FAILED %s (%s): expected %0h, actual %0h", testName, cmpName,
				cmpExp, cmpAct);
			errorCount++;
			testErrors++;
		end
	end

	task automatic checkValue(string name, logic [47:0] exp, logic [47:0] act);
		cmpName = name;
		cmpExp  = exp;
		cmpAct  = act;
		->checkReq;
		#1;
	endtask

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	task automatic nextCycle();
		@(posedge clk6M);
		#DRIVE_DELAY;
	endtask

	task automatic startTest(string name);
		testName   = name;
		testChecks = 0;
		testErrors = 0;
	endtask

	task automatic endTest();
		testCount++;
		$display("test %s: %0d checks, %0d errors, %s", testName, testChecks, testErrors,
			(testErrors == 0) ? "ok" : "fail");
	endtask

	task automatic stopOnTimeout(string what);
		$display("Timeout: %s", what);
		$display("ERRORS FOUND");
		$finish;
	endtask

	// Model side effects of one strobed write
	task automatic noteWrite(logic [15:0] a, logic [7:0] d);
		if (a >= 16'hD000) begin
			if (a <= 16'hDFFF) begin
				shadow[a[2:0]] = d;
			end
		end
		if (a >= 16'h8000 && a < 16'h8800) begin
			modelPending = 1'b1;
		end
		if (a >= 16'h8800 && a < 16'h9000) begin
			modelIrq = 1'b0;
		end
	endtask

	task automatic noteVblankStart();
		modelCount   = nextWdCount(modelCount, modelPending);
		modelPending = 1'b0;
		modelIrq     = 1'b1;
	endtask

	// One cycle strobe, returns just after the edge that took it
	task automatic applyWrite(logic [15:0] a, logic [7:0] d);
		nextCycle();
		bus.addr  = a;
		bus.data  = d;
		bus.write = 1'b1;
		noteWrite(a, d);
		nextCycle();
		bus.write = 1'b0;
	endtask

	task automatic pulseVblank();
		nextCycle();
		vblank = 1'b1;
		noteVblankStart();
		repeat (3) nextCycle();
		vblank = 1'b0;
		repeat (3) nextCycle();
		@(negedge clk6M);
	endtask

	task automatic waitForIrq();
		int cycles;
		cycles = 0;
		while (mainIrq !== 1'b1 && cycles < 16) begin
			nextCycle();
			cycles++;
		end
		if (mainIrq !== 1'b1) begin
			stopOnTimeout("mainIrq did not rise after vblank start");
		end
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		logic [15:0] a;
		logic [7:0]  d;
		int          riseAt;
		int          fallAt;
		int          frames;
		reset = 1'b1;
		vblank = 1'b0;
		clk0 = 1'b0;
		bus = '0;
		lfsrState = 32'hb8ee_b48f;
		modelCount = 0;
		modelPending = 1'b0;
		modelIrq = 1'b0;
		modelPhase = 2'd0;
		testCount = 0;
		checkCount = 0;
		errorCount = 0;
		for (int k = 0; k < 8; k++) begin
			shadow[k] = 8'h00;
		end
		repeat (2) @(posedge clk6M);
		#DRIVE_DELAY;
		reset = 1'b0;

		startTest("reset state");
		@(negedge clk6M);
		checkValue("tileRegs", '0, tileRegs);
		checkValue("mainReset", 1'b0, mainReset);
		checkValue("mainIrq", 1'b0, mainIrq);
		checkValue("cpuQ", 1'b0, cpuQ);
		endTest();

		// Each address is decoded as a read, then as a one cycle write
		startTest("chip selects");
		for (int i = 0; i < 200; i++) begin
			a = 16'(takeBits(16));
			d = 8'(takeBits(8));
			nextCycle();
			bus.addr  = a;
			bus.data  = 8'h00;
			bus.write = 1'b0;
			@(negedge clk6M);
			checkValue("read decode", refChipSel(a, 1'b0), chipSel);
			nextCycle();
			bus.data  = d;
			bus.write = 1'b1;
			noteWrite(a, d);
			@(negedge clk6M);
			checkValue("write decode", refChipSel(a, 1'b1), chipSel);
		end
		nextCycle();
		bus.write = 1'b0;
		@(negedge clk6M);
		checkValue("tileRegs after random writes", refTileRegs(), tileRegs);
		endTest();

		// Every offset of both windows, window picked at random
		startTest("tile latches");
		for (int i = 0; i < 64; i++) begin
			a = {(takeBits(1) ? `LATCH1_BASE : `LATCH0_BASE), 8'(takeBits(8)), 3'(i)};
			applyWrite(a, 8'(takeBits(8)));
			@(negedge clk6M);
			checkValue("tileRegs", refTileRegs(), tileRegs);
		end
		endTest();

		// Kick once so the count starts from zero
		startTest("watchdog idle");
		applyWrite({`WDOG_ADDR, 11'h000}, 8'h00);
		pulseVblank();
		riseAt = 0;
		fallAt = 0;
		for (int n = 1; n <= RESET_FALL_FRAME; n++) begin
			pulseVblank();
			checkValue("mainReset", refReset(modelCount), mainReset);
			if (mainReset === 1'b1 && riseAt == 0) begin
				riseAt = n;
			end
			if (mainReset === 1'b0 && riseAt != 0 && fallAt == 0) begin
				fallAt = n;
			end
		end
		checkValue("reset rise frame", RESET_RISE_FRAME, riseAt);
		checkValue("reset fall frame", RESET_FALL_FRAME, fallAt);
		endTest();

		startTest("watchdog kicked");
		for (int i = 0; i < 12; i++) begin
			applyWrite({`WDOG_ADDR, 11'(takeBits(11))}, 8'(takeBits(8)));
			pulseVblank();
			checkValue("mainReset", refReset(modelCount), mainReset);
		end
		// Restart from zero shows up as a full run to the rise
		frames = 0;
		while (mainReset !== 1'b1 && frames < 16) begin
			pulseVblank();
			frames++;
		end
		if (mainReset !== 1'b1) begin
			stopOnTimeout("mainReset never rose after kicks stopped");
		end else begin
			checkValue("frames to reset", RESET_RISE_FRAME, frames);
		end
		endTest();

		startTest("vblank irq");
		applyWrite({`INTACK_ADDR, 11'(takeBits(11))}, 8'h00);
		@(negedge clk6M);
		checkValue("irq after ack", modelIrq, mainIrq);
		for (int i = 0; i < 4; i++) begin
			nextCycle();
			vblank = 1'b1;
			noteVblankStart();
			waitForIrq();
			repeat (2) nextCycle();
			vblank = 1'b0;
			// Irq stays up past the end of vblank until acknowledged
			nextCycle();
			@(negedge clk6M);
			checkValue("irq held", modelIrq, mainIrq);
			applyWrite({`INTACK_ADDR, 11'(takeBits(11))}, 8'(takeBits(8)));
			@(negedge clk6M);
			checkValue("irq after ack", modelIrq, mainIrq);
		end
		endTest();

		// clk0 high, dropped low for three clocks, then high again
		startTest("cpu phase");
		for (int i = 0; i < 24; i++) begin
			nextCycle();
			// clk0 as it was at this edge
			modelPhase = clk0 ? modelPhase + 2'd1 : 2'd0;
			clk0 = (i < 12) || (i >= 15);
			@(negedge clk6M);
			checkValue("cpuQ", refCpuQ(modelPhase), cpuQ);
		end
		endTest();

		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+logic
logic/sys86Pkg.sv
logic/cpuPhaseGen.sv
logic/mainAddrDecoder.sv
logic/vblankWatchdog.sv
logic/tileLatchBank.sv
logic/mainBusCtrl.sv
verif/tbMainBusCtrl.sv
